//--- rtl/pe_array_cfg.svh
`ifndef PE_ARRAY_CFG_SVH
`define PE_ARRAY_CFG_SVH

// grid dimensions
`define PE_ROWS   4   // cells per column
`define PE_COLS   4   // cells per row

// operand width, shared by data and weight bytes
`define PE_DATA_W 8

// partial sum width, sums wrap modulo 2**17
`define PE_PSUM_W 17

`endif

//--- rtl/pe_array_pkg.sv
`include "pe_array_cfg.svh"

package pe_array_pkg;

    typedef logic [`PE_DATA_W-1:0] data_t;    // one data byte
    typedef logic [`PE_DATA_W-1:0] weight_t;  // one weight byte
    typedef logic [`PE_PSUM_W-1:0] psum_t;    // one partial sum

    // horizontal link between neighbours, data in the low byte
    typedef struct packed {
        psum_t psum;
        data_t data;
    } pe_link_t;

    // one host beat
    typedef struct packed {
        data_t   [`PE_ROWS-1:0] row_data;    // left edge, one byte per row
        weight_t [`PE_COLS-1:0] col_weight;  // top edge, one byte per column
        logic                   last;        // closes the job
    } beat_t;

    // right edge psums, one per row
    typedef psum_t [`PE_ROWS-1:0] row_psum_t;

endpackage

//--- rtl/pe_cell.sv
`timescale 1ns/1ps

module pe_cell import pe_array_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     step,       // advance one step
    input  logic     clear,      // job boundary, wins over step
    input  pe_link_t link_in,    // from left neighbour or host
    input  weight_t  weight_in,  // from cell above or host
    output pe_link_t link_out,   // to right neighbour
    output weight_t  weight_out  // to cell below
);

    pe_link_t link_q;
    weight_t  weight_q;

    // multiply-accumulate, operands widen to the psum width before the multiply
    logic [$bits(link_in.psum)-1:0] mac_sum;

    assign mac_sum = link_in.psum + link_in.data * weight_in;  // wraps on overflow

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            link_q.data <= '0;
            link_q.psum <= '0;
            weight_q    <= '0;
        end else if (clear) begin
            link_q.data <= '0;  // drop the finished job
            link_q.psum <= '0;
            weight_q    <= '0;
        end else if (step) begin
            link_q.data <= link_in.data;  // data moves right
            link_q.psum <= mac_sum;       // running sum moves right
            weight_q    <= weight_in;     // weight moves down
        end
    end

    assign link_out   = link_q;
    assign weight_out = weight_q;

endmodule

//--- rtl/pe_grid.sv
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module pe_grid import pe_array_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,        // one-cycle advance of every cell
    input  logic                     clear,       // one-cycle clear of every cell
    input  data_t   [`PE_ROWS-1:0]   row_data,    // host bytes for the left column
    input  weight_t [`PE_COLS-1:0]   col_weight,  // host bytes for the top row
    output row_psum_t                result       // right column psums
);

    // horizontal mesh, column 0 is the host side and column PE_COLS the right edge
    pe_link_t link_w [`PE_ROWS][`PE_COLS+1];

    // vertical mesh, row 0 is the host side
    // the last row leaves the array unread
    weight_t  weight_w [`PE_ROWS+1][`PE_COLS];

    genvar r;
    genvar c;

    // left edge: host data enters with nothing accumulated yet
    generate
        for (r = 0; r < `PE_ROWS; r++) begin : g_left
            assign link_w[r][0].data = row_data[r];
            assign link_w[r][0].psum = '0;
        end
    endgenerate

    // top edge: host weights
    generate
        for (c = 0; c < `PE_COLS; c++) begin : g_top
            assign weight_w[0][c] = col_weight[c];
        end
    endgenerate

    // cell array
    // the corner cell sits on both edges and so takes data and weight from the host
    generate
        for (r = 0; r < `PE_ROWS; r++) begin : g_row
            for (c = 0; c < `PE_COLS; c++) begin : g_col
                pe_cell cell0 (
                    .clk        (clk),
                    .reset      (reset),
                    .step       (step),
                    .clear      (clear),
                    .link_in    (link_w[r][c]),
                    .weight_in  (weight_w[r][c]),
                    .link_out   (link_w[r][c+1]),
                    .weight_out (weight_w[r+1][c])
                );
            end
        end
    endgenerate

    // right edge, each row's finished psum
    generate
        for (r = 0; r < `PE_ROWS; r++) begin : g_right
            assign result[r] = link_w[r][`PE_COLS].psum;  // data byte ends here
        end
    endgenerate

endmodule

//--- rtl/step_controller.sv
`timescale 1ns/1ps

module step_controller (
    input  logic clk,
    input  logic reset,
    input  logic req,    // host beat request, four-phase
    input  logic last,   // beat closes the job
    output logic ack,    // beat done, result valid
    output logic step,   // advance the grid once
    output logic clear   // clear the grid at job end
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_STEP  = 2'd1;
    localparam logic [1:0] ST_ACK   = 2'd2;
    localparam logic [1:0] ST_CLEAR = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       last_q;  // copy of last taken with the beat

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_nxt = ST_STEP;
                end
            end
            ST_STEP: begin
                state_nxt = ST_ACK;  // grid updates on this edge
            end
            ST_ACK: begin
                // hold while req stays high, no further steps
                if (!req) begin
                    if (last_q) begin
                        state_nxt = ST_CLEAR;
                    end else begin
                        state_nxt = ST_IDLE;
                    end
                end
            end
            ST_CLEAR: begin
                state_nxt = ST_IDLE;  // pending req is taken from idle
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the beat is stable while req is high, so sample last on acceptance
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_q <= 1'b0;
        end else if (state == ST_IDLE && req) begin
            last_q <= last;
        end
    end

    // outputs decoded from the state register
    assign step  = (state == ST_STEP);
    assign ack   = (state == ST_ACK);
    assign clear = (state == ST_CLEAR);

endmodule

//--- rtl/pe_array_top.sv
`timescale 1ns/1ps

module pe_array_top import pe_array_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req,     // four-phase request
    input  beat_t     beat,    // held stable while req is high
    output logic      ack,     // four-phase acknowledge
    output row_psum_t result   // valid while ack is high
);

    logic step;
    logic clear;

    // handshake and sequencing
    step_controller ctrl0 (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .last  (beat.last),
        .ack   (ack),
        .step  (step),
        .clear (clear)
    );

    // datapath, beat arrays go straight to the edges
    pe_grid grid0 (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .clear      (clear),
        .row_data   (beat.row_data),
        .col_weight (beat.col_weight),
        .result     (result)
    );

endmodule

//--- test/pe_array_checker.sv
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module pe_array_checker import pe_array_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  beat_t     beat,
    input  logic      ack,
    input  row_psum_t result,
    output int        error_count
);

    beat_t     hist[$];     // beats of the current job
    logic      req_q;
    logic      ack_q;
    logic      seen_req;    // any beat offered since reset
    row_psum_t held;        // result captured at ack rise
    row_psum_t expected;

    // right edge psums after beat k of the job
    // row r sees data of beat m against weights skewed by column and row
    function automatic row_psum_t reference_result(input int k);
        row_psum_t res;
        longint    wsum;
        longint    prod;
        int        m;
        int        idx;
        m = k - `PE_COLS + 1;
        for (int r = 0; r < `PE_ROWS; r++) begin
            res[r] = '0;
            if (m >= 0) begin
                wsum = 0;
                for (int c = 0; c < `PE_COLS; c++) begin
                    idx = m + c - r;
                    if (idx >= 0)
                        wsum += hist[idx].col_weight[c];
                end
                prod = hist[m].row_data[r] * wsum;
                res[r] = psum_t'(prod);  // wraps modulo 2**PE_PSUM_W
            end
        end
        return res;
    endfunction

    // sampled mid-cycle, where req, ack and result are settled
    always @(negedge clk or posedge reset) begin
        if (reset) begin
            hist.delete();
            req_q       = 1'b0;
            ack_q       = 1'b0;
            seen_req    = 1'b0;
            held        = '0;
            error_count = 0;
        end else begin
            if (req && !req_q) begin
                hist.push_back(beat);  // new beat offered
                seen_req = 1'b1;
            end
            if (!seen_req && ack !== 1'b0) begin
                $display("CHECK FAILED time=%0t ack expected=0 actual=%b", $time, ack);
                error_count++;
            end
            if (!seen_req && result !== '0) begin
                $display("CHECK FAILED time=%0t result expected=0 actual=%h", $time, result);
                error_count++;
            end
            if (ack && !ack_q) begin
                if (hist.size() == 0) begin
                    $display("ack rose at %0t without any beat having been offered", $time);
                    error_count++;
                end else begin
                    expected = reference_result(hist.size() - 1);
                    for (int r = 0; r < `PE_ROWS; r++) begin
                        if (result[r] !== expected[r]) begin
                            $display("CHECK FAILED time=%0t result[%0d] expected=%h actual=%h",
                                     $time, r, expected[r], result[r]);
                            error_count++;
                        end
                    end
                    if (hist[hist.size()-1].last)
                        hist.delete();  // job done, grid gets cleared
                end
                held = result;
            end else if (ack && result !== held) begin
                // extra step while ack is held high
                $display("CHECK FAILED time=%0t result expected=%h actual=%h",
                         $time, held, result);
                error_count++;
                held = result;
            end
            req_q = req;
            ack_q = ack;
        end
    end

endmodule

//--- test/tb_pe_array.sv
`timescale 1ns/1ps
`include "pe_array_cfg.svh"

module tb_pe_array import pe_array_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      req;
    beat_t     beat;
    logic      ack;
    row_psum_t result;
    int        check_errors;
    int        timeout_count;

    pe_array_top dut0 (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .beat   (beat),
        .ack    (ack),
        .result (result)
    );

    pe_array_checker chk0 (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .beat        (beat),
        .ack         (ack),
        .result      (result),
        .error_count (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic beat_t random_beat(input logic last);
        beat_t b;
        for (int r = 0; r < `PE_ROWS; r++)
            b.row_data[r] = data_t'($urandom);
        for (int c = 0; c < `PE_COLS; c++)
            b.col_weight[c] = weight_t'($urandom);
        b.last = last;
        return b;
    endfunction

    // polls just after each edge, gives up after 20 cycles
    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ack !== level) begin
            $display("timeout at %0t: ack did not go to %0b within 20 cycles", $time, level);
            timeout_count++;
        end
    endtask

    // one four-phase exchange, req held for extra cycles after ack
    task automatic send_beat(input beat_t b, input int extra_hold);
        @(posedge clk);
        #1;
        beat = b;
        req  = 1'b1;
        wait_ack(1'b1);
        repeat (extra_hold) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic run_job(input int beats, input logic all_ones, input int max_hold);
        beat_t b;
        int    hold;
        for (int i = 0; i < beats; i++) begin
            if (all_ones) begin
                b      = '1;  // every byte 255
                b.last = (i == beats - 1);
            end else begin
                b = random_beat(i == beats - 1);
            end
            hold = (max_hold > 0) ? ($urandom % (max_hold + 1)) : 0;
            send_beat(b, hold);
        end
    endtask

    initial begin
        void'($urandom(32'h0665_6bc8));
        timeout_count = 0;
        reset = 1'b1;
        req   = 1'b0;
        beat  = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) @(posedge clk);  // idle window, checker sees ack and result at zero

        run_job(12, 1'b0, 0);       // random job, closes with last
        run_job(8, 1'b0, 6);        // fresh history, req held back
        run_job(8, 1'b1, 0);        // psum wrap
        repeat (3) @(posedge clk);

        $display("errors: checks %0d, timeouts %0d", check_errors, timeout_count);
        if (check_errors == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/pe_array_pkg.sv
rtl/pe_cell.sv
rtl/pe_grid.sv
rtl/step_controller.sv
rtl/pe_array_top.sv
test/pe_array_checker.sv
test/tb_pe_array.sv
